/* list.f */
source/csr_pkg.sv
source/irq_channel.sv
source/csr_counters.sv
source/csr_regs.sv
source/csr_top.sv
tb/csr_asserts.sv
tb/csr_tb.sv

/* source/csr_counters.sv */
`timescale 1ns/10ps

module csr_counters (
    input  logic              clk,
    input  logic              rst_n,
    input  csr_pkg::csr_req_t idex_req_i,
    input  csr_pkg::cnt_en_t  cnt_en_i,
    input  logic              retire_i,
    output csr_pkg::cnt_val_t cnt_o,
    output logic              tmr_hit_o
);
    import csr_pkg::*;

    logic [63:0] mcycle_q;
    logic [63:0] minstret_q;
    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;

    logic wr_cyc_lo, wr_cyc_hi;
    logic wr_ins_lo, wr_ins_hi;
    logic wr_tim_lo, wr_tim_hi;
    logic wr_cmp_lo, wr_cmp_hi;

    // a half write takes precedence over the increment
    function automatic logic [63:0] next_cnt(
        input logic [63:0]     cur,
        input logic            wr_lo,
        input logic            wr_hi,
        input logic            inc,
        input logic [XLEN-1:0] wdata
    );
        logic [63:0] nxt;
        nxt = cur;
        if (wr_lo) begin
            nxt[31:0] = wdata;
        end else if (wr_hi) begin
            nxt[63:32] = wdata;
        end else if (inc) begin
            nxt = cur + 64'd1;
        end
        return nxt;
    endfunction

    assign wr_cyc_lo = idex_req_i.we && (idex_req_i.addr == CSR_MCYCLE);
    assign wr_cyc_hi = idex_req_i.we && (idex_req_i.addr == CSR_MCYCLEH);
    assign wr_ins_lo = idex_req_i.we && (idex_req_i.addr == CSR_MINSTRET);
    assign wr_ins_hi = idex_req_i.we && (idex_req_i.addr == CSR_MINSTRETH);
    assign wr_tim_lo = idex_req_i.we && (idex_req_i.addr == CSR_MTIME);
    assign wr_tim_hi = idex_req_i.we && (idex_req_i.addr == CSR_MTIMEH);
    assign wr_cmp_lo = idex_req_i.we && (idex_req_i.addr == CSR_MTIMECMP);
    assign wr_cmp_hi = idex_req_i.we && (idex_req_i.addr == CSR_MTIMECMPH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;   // compare idle until programmed
        end else begin
            mcycle_q   <= next_cnt(mcycle_q, wr_cyc_lo, wr_cyc_hi,
                                   cnt_en_i.cycle, idex_req_i.wdata);
            minstret_q <= next_cnt(minstret_q, wr_ins_lo, wr_ins_hi,
                                   cnt_en_i.instret & retire_i, idex_req_i.wdata);
            mtime_q    <= next_cnt(mtime_q, wr_tim_lo, wr_tim_hi,
                                   cnt_en_i.timer, idex_req_i.wdata);
            mtimecmp_q <= next_cnt(mtimecmp_q, wr_cmp_lo, wr_cmp_hi,
                                   1'b0, idex_req_i.wdata);
        end
    end

    assign cnt_o.mcycle   = mcycle_q;
    assign cnt_o.minstret = minstret_q;
    assign cnt_o.mtime    = mtime_q;
    assign cnt_o.mtimecmp = mtimecmp_q;

    assign tmr_hit_o = (mtime_q >= mtimecmp_q);   // level, not a pulse

endmodule

/* source/csr_pkg.sv */
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // standard machine registers
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MISA      = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL     = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP       = 12'h344;

    // custom space
    localparam logic [CSR_ADDR_W-1:0] CSR_MTRIG     = 12'h7c0;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSIP      = 12'h7c1;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTIME     = 12'h7c2;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTIMEH    = 12'h7c3;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTIMECMP  = 12'h7c4;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTIMECMPH = 12'h7c5;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCCTR     = 12'h7c6;

    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE    = 12'hb00;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET  = 12'hb02;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH   = 12'hb80;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRETH = 12'hb82;

    // read-only identity registers
    localparam logic [CSR_ADDR_W-1:0] CSR_MVENDORID = 12'hf11;
    localparam logic [CSR_ADDR_W-1:0] CSR_MARCHID   = 12'hf12;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIMPID    = 12'hf13;
    localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID   = 12'hf14;

    localparam logic [XLEN-1:0] MISA_VAL    = 32'h4000_1100; // mxl=1, i and m
    localparam logic [XLEN-1:0] MARCHID_VAL = 32'd1;
    localparam logic [XLEN-1:0] MIMPID_VAL  = 32'd1;

    typedef enum logic [1:0] {
        TRIG_HIGH = 2'b00,
        TRIG_LOW  = 2'b01,
        TRIG_RISE = 2'b10,
        TRIG_FALL = 2'b11
    } trig_mode_t;

    typedef struct packed {
        logic                  we;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       wdata;
    } csr_req_t;

    typedef struct packed {
        logic ext;
        logic tmr;
        logic sw;
    } irq_t;

    // mcctr enables in bits 0 to 2
    typedef struct packed {
        logic timer;
        logic instret;
        logic cycle;
    } cnt_en_t;

    typedef struct packed {
        logic [63:0] mcycle;
        logic [63:0] minstret;
        logic [63:0] mtime;
        logic [63:0] mtimecmp;
    } cnt_val_t;

endpackage

/* source/csr_regs.sv */
`timescale 1ns/10ps

module csr_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  csr_pkg::csr_req_t        idex_req_i,
    input  csr_pkg::csr_req_t        trap_req_i,
    output logic [csr_pkg::XLEN-1:0] idex_rdata_o,
    output logic [csr_pkg::XLEN-1:0] trap_rdata_o,
    input  csr_pkg::cnt_val_t        cnt_i,
    input  csr_pkg::irq_t            pend_i,
    input  logic                     retire_i,
    output csr_pkg::cnt_en_t         cnt_en_o,
    output csr_pkg::trig_mode_t      ext_mode_o,
    output csr_pkg::trig_mode_t      tmr_mode_o,
    output csr_pkg::trig_mode_t      sw_mode_o,
    output logic                     sw_src_o,
    output logic [csr_pkg::XLEN-1:0] mepc_o,
    output logic                     soft_rst_o,
    output logic                     mie_global_o,
    output csr_pkg::irq_t            irq_o
);
    import csr_pkg::*;

    logic            mst_mie, mst_mpie;          // mstatus bits 3 and 7
    logic            mie_meie, mie_mtie, mie_msie;
    logic [XLEN-1:0] mtvec, mscratch, mepc, mcause, mtval;
    logic [XLEN-1:0] msip;
    logic [5:0]      mtrig;                      // 2 bits per source
    logic [3:0]      mcctr;
    logic            trap_we;
    irq_t            irq_q;

    assign trap_we = trap_req_i.we & ~idex_req_i.we;   // idex wins

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mst_mie  <= 1'b0;
            mst_mpie <= 1'b0;
            mie_meie <= 1'b0;
            mie_mtie <= 1'b0;
            mie_msie <= 1'b0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            msip     <= '0;
            mtrig    <= '0;
            mcctr    <= '0;
        end else if (idex_req_i.we) begin
            case (idex_req_i.addr)
                CSR_MSTATUS: begin
                    mst_mie  <= idex_req_i.wdata[3];
                    mst_mpie <= idex_req_i.wdata[7];
                end
                CSR_MIE: begin
                    mie_meie <= idex_req_i.wdata[11];
                    mie_mtie <= idex_req_i.wdata[7];
                    mie_msie <= idex_req_i.wdata[3];
                end
                CSR_MTVEC:    mtvec    <= idex_req_i.wdata;
                CSR_MSCRATCH: mscratch <= idex_req_i.wdata;
                CSR_MEPC:     mepc     <= idex_req_i.wdata;
                CSR_MCAUSE:   mcause   <= idex_req_i.wdata;
                CSR_MTVAL:    mtval    <= idex_req_i.wdata;
                CSR_MTRIG:    mtrig    <= idex_req_i.wdata[5:0];
                CSR_MSIP:     msip     <= idex_req_i.wdata;
                CSR_MCCTR:    mcctr    <= idex_req_i.wdata[3:0];
                default: ;   // counters decode their own
            endcase
        end else if (trap_we) begin
            case (trap_req_i.addr)
                CSR_MSTATUS: begin
                    mst_mie  <= trap_req_i.wdata[3];
                    mst_mpie <= trap_req_i.wdata[7];
                end
                CSR_MTVEC:  mtvec  <= trap_req_i.wdata;
                CSR_MEPC:   mepc   <= trap_req_i.wdata;
                CSR_MCAUSE: mcause <= trap_req_i.wdata;
                CSR_MTVAL:  mtval  <= trap_req_i.wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (idex_req_i.addr)
            CSR_MSTATUS:   idex_rdata_o = {19'h0, 2'b11, 3'h0, mst_mpie, 3'h0, mst_mie, 3'h0};
            CSR_MISA:      idex_rdata_o = MISA_VAL;
            CSR_MIE:       idex_rdata_o = {20'h0, mie_meie, 3'h0, mie_mtie, 3'h0,
                                           mie_msie, 3'h0};
            CSR_MTVEC:     idex_rdata_o = mtvec;
            CSR_MSCRATCH:  idex_rdata_o = mscratch;
            CSR_MEPC:      idex_rdata_o = mepc;
            CSR_MCAUSE:    idex_rdata_o = mcause;
            CSR_MTVAL:     idex_rdata_o = mtval;
            CSR_MIP:       idex_rdata_o = {20'h0, pend_i.ext, 3'h0, pend_i.tmr, 3'h0,
                                           pend_i.sw, 3'h0};
            CSR_MTRIG:     idex_rdata_o = {26'h0, mtrig};
            CSR_MSIP:      idex_rdata_o = msip;
            CSR_MCYCLE:    idex_rdata_o = cnt_i.mcycle[31:0];
            CSR_MCYCLEH:   idex_rdata_o = cnt_i.mcycle[63:32];
            CSR_MINSTRET:  idex_rdata_o = cnt_i.minstret[31:0];
            CSR_MINSTRETH: idex_rdata_o = cnt_i.minstret[63:32];
            CSR_MTIME:     idex_rdata_o = cnt_i.mtime[31:0];
            CSR_MTIMEH:    idex_rdata_o = cnt_i.mtime[63:32];
            CSR_MTIMECMP:  idex_rdata_o = cnt_i.mtimecmp[31:0];
            CSR_MTIMECMPH: idex_rdata_o = cnt_i.mtimecmp[63:32];
            CSR_MCCTR:     idex_rdata_o = {28'h0, mcctr};
            CSR_MARCHID:   idex_rdata_o = MARCHID_VAL;
            CSR_MIMPID:    idex_rdata_o = MIMPID_VAL;
            default:       idex_rdata_o = '0;   // vendorid, hartid, unknown
        endcase
    end

    // trap side sees only its own five, mpp not reported
    always_comb begin
        case (trap_req_i.addr)
            CSR_MSTATUS: trap_rdata_o = {24'h0, mst_mpie, 3'h0, mst_mie, 3'h0};
            CSR_MTVEC:   trap_rdata_o = mtvec;
            CSR_MEPC:    trap_rdata_o = mepc;
            CSR_MCAUSE:  trap_rdata_o = mcause;
            CSR_MTVAL:   trap_rdata_o = mtval;
            default:     trap_rdata_o = '0;
        endcase
    end

    // mask sampled only when an instruction retires
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q <= '0;
        end else if (retire_i) begin
            irq_q.ext <= pend_i.ext & mie_meie;
            irq_q.tmr <= pend_i.tmr & mie_mtie;
            irq_q.sw  <= pend_i.sw & mie_msie;
        end
    end

    assign irq_o            = irq_q;
    assign cnt_en_o.cycle   = mcctr[0];
    assign cnt_en_o.instret = mcctr[1];
    assign cnt_en_o.timer   = mcctr[2];
    assign soft_rst_o       = mcctr[3];
    assign ext_mode_o       = trig_mode_t'(mtrig[1:0]);
    assign tmr_mode_o       = trig_mode_t'(mtrig[3:2]);
    assign sw_mode_o        = trig_mode_t'(mtrig[5:4]);
    assign sw_src_o         = |msip;   // any nonzero value requests
    assign mepc_o           = mepc;
    assign mie_global_o     = mst_mie;

endmodule

/* source/csr_top.sv */
`timescale 1ns/10ps

module csr_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  csr_pkg::csr_req_t        idex_req_i,
    input  csr_pkg::csr_req_t        trap_req_i,
    output logic [csr_pkg::XLEN-1:0] idex_rdata_o,
    output logic [csr_pkg::XLEN-1:0] trap_rdata_o,
    output logic [csr_pkg::XLEN-1:0] mepc_o,
    output logic                     soft_rst_o,
    input  logic                     ext_irq_i,
    input  csr_pkg::irq_t            irq_rsp_i,
    input  logic                     retire_i,
    output csr_pkg::irq_t            irq_o,
    output logic                     mie_global_o
);
    import csr_pkg::*;

    cnt_val_t   cnt;
    cnt_en_t    cnt_en;
    logic       tmr_hit;
    logic       sw_src;
    irq_t       pend;
    trig_mode_t ext_mode, tmr_mode, sw_mode;

    csr_counters u_counters (
        .clk        (clk),
        .rst_n      (rst_n),
        .idex_req_i (idex_req_i),
        .cnt_en_i   (cnt_en),
        .retire_i   (retire_i),
        .cnt_o      (cnt),
        .tmr_hit_o  (tmr_hit)
    );

    csr_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .idex_req_i   (idex_req_i),
        .trap_req_i   (trap_req_i),
        .idex_rdata_o (idex_rdata_o),
        .trap_rdata_o (trap_rdata_o),
        .cnt_i        (cnt),
        .pend_i       (pend),
        .retire_i     (retire_i),
        .cnt_en_o     (cnt_en),
        .ext_mode_o   (ext_mode),
        .tmr_mode_o   (tmr_mode),
        .sw_mode_o    (sw_mode),
        .sw_src_o     (sw_src),
        .mepc_o       (mepc_o),
        .soft_rst_o   (soft_rst_o),
        .mie_global_o (mie_global_o),
        .irq_o        (irq_o)
    );

    irq_channel u_irq_ext (
        .clk    (clk),
        .rst_n  (rst_n),
        .src_i  (ext_irq_i),
        .mode_i (ext_mode),
        .rsp_i  (irq_rsp_i.ext),
        .pend_o (pend.ext)
    );

    irq_channel u_irq_tmr (
        .clk    (clk),
        .rst_n  (rst_n),
        .src_i  (tmr_hit),   // mtime >= mtimecmp
        .mode_i (tmr_mode),
        .rsp_i  (irq_rsp_i.tmr),
        .pend_o (pend.tmr)
    );

    irq_channel u_irq_sw (
        .clk    (clk),
        .rst_n  (rst_n),
        .src_i  (sw_src),
        .mode_i (sw_mode),
        .rsp_i  (irq_rsp_i.sw),
        .pend_o (pend.sw)
    );

endmodule

/* source/irq_channel.sv */
`timescale 1ns/10ps

module irq_channel (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                src_i,
    input  csr_pkg::trig_mode_t mode_i,
    input  logic                rsp_i,
    output logic                pend_o
);
    import csr_pkg::*;

    logic src_q;   // last cycle's source
    logic trig;
    logic pend_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_q <= 1'b0;
        end else begin
            src_q <= src_i;
        end
    end

    always_comb begin
        case (mode_i)
            TRIG_HIGH: trig = src_i;
            TRIG_LOW:  trig = ~src_i;
            TRIG_RISE: trig = src_i & ~src_q;
            TRIG_FALL: trig = ~src_i & src_q;
            default:   trig = 1'b0;
        endcase
    end

    // sticky until the trap logic responds
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
        end else if (pend_q) begin
            if (rsp_i) pend_q <= 1'b0;   // response clears
        end else if (trig) begin
            pend_q <= 1'b1;
        end
    end

    assign pend_o = pend_q;

endmodule

/* tb/csr_asserts.sv */
`timescale 1ns/10ps

module csr_asserts (
    input logic                     clk,
    input logic                     rst_n,
    input csr_pkg::csr_req_t        idex_req_i,
    input csr_pkg::csr_req_t        trap_req_i,
    input logic [csr_pkg::XLEN-1:0] mepc_o,
    input logic                     soft_rst_o,
    input logic                     retire_i,
    input csr_pkg::irq_t            irq_o
);
    import csr_pkg::*;

    logic mcctr_wr;
    logic trap_mepc_wr;

    assign mcctr_wr     = idex_req_i.we && (idex_req_i.addr == CSR_MCCTR);
    assign trap_mepc_wr = trap_req_i.we && !idex_req_i.we && (trap_req_i.addr == CSR_MEPC);

    // gated outputs move only on a retire edge
    irq_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(retire_i) |-> (irq_o == $past(irq_o)))
        else begin
            $error("irq_o changed without retire_i");
            csr_tb.assert_errs = csr_tb.assert_errs + 1;
        end

    soft_rst_follows: assert property (@(posedge clk) disable iff (!rst_n)
        mcctr_wr |=> (soft_rst_o == $past(idex_req_i.wdata[3])))
        else begin
            $error("soft_rst_o does not follow mcctr bit 3");
            csr_tb.assert_errs = csr_tb.assert_errs + 1;
        end

    // trap port owns mepc when idex is quiet
    trap_mepc_lands: assert property (@(posedge clk) disable iff (!rst_n)
        trap_mepc_wr |=> (mepc_o == $past(trap_req_i.wdata)))
        else begin
            $error("trap write to mepc did not land");
            csr_tb.assert_errs = csr_tb.assert_errs + 1;
        end

endmodule

/* tb/csr_tb.sv */
`timescale 1ns/10ps

module csr_tb;
    import csr_pkg::*;

    logic            clk;
    logic            rst_n;
    csr_req_t        idex_req, trap_req;
    logic [XLEN-1:0] idex_rdata, trap_rdata, mepc;
    logic            soft_rst, ext_irq, retire, mie_global;
    irq_t            irq_rsp, irq;
    logic [31:0]     lcg_state;
    int              assert_errs;   // bumped by the bound checker

    csr_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .idex_req_i   (idex_req),
        .trap_req_i   (trap_req),
        .idex_rdata_o (idex_rdata),
        .trap_rdata_o (trap_rdata),
        .mepc_o       (mepc),
        .soft_rst_o   (soft_rst),
        .ext_irq_i    (ext_irq),
        .irq_rsp_i    (irq_rsp),
        .retire_i     (retire),
        .irq_o        (irq),
        .mie_global_o (mie_global)
    );

    bind csr_top csr_asserts u_asserts (.*);

    initial begin
        clk = 1'b1;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_irq(input irq_t got, input irq_t exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
            stop_on_error();
        end
    endtask

    // one cycle of requests and both ports idle afterwards
    task automatic write_ports(input csr_req_t ireq, input csr_req_t treq);
        @(negedge clk);
        idex_req = ireq;
        trap_req = treq;
        @(negedge clk);
        idex_req = '0;
        trap_req = '0;
    endtask

    task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [31:0] data);
        write_ports(csr_req_t'{1'b1, addr, data}, '0);
    endtask

    task automatic csr_read(input bit on_trap, input logic [CSR_ADDR_W-1:0] addr,
                            output logic [31:0] data);
        @(negedge clk);
        if (on_trap) trap_req = csr_req_t'{1'b0, addr, 32'h0};
        else idex_req = csr_req_t'{1'b0, addr, 32'h0};
        #2;   // reads settle well before the next edge
        data = on_trap ? trap_rdata : idex_rdata;
    endtask

    task automatic pulse_retire(input int n);
        repeat (n) begin
            @(negedge clk);
            retire = 1'b1;
            @(negedge clk);
            retire = 1'b0;
        end
    endtask

    task automatic respond(input irq_t r);
        @(negedge clk);
        irq_rsp = r;
        @(negedge clk);
        irq_rsp = '0;
    endtask

    task automatic wait_mip(input logic [31:0] mask, input logic [31:0] want,
                            input string what);
        logic [31:0] v;
        int          n;
        n = 0;
        csr_read(1'b0, CSR_MIP, v);
        while ((v & mask) != want) begin
            n++;
            if (n > 20) begin
                $display("timeout at %0t: mip never showed %s", $time, what);
                stop_on_error();
            end
            csr_read(1'b0, CSR_MIP, v);
        end
    endtask

    task automatic exercise_registers();
        logic [CSR_ADDR_W-1:0] addrs[6];
        logic [31:0]           val, rd;
        addrs = '{CSR_MSCRATCH, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MTRIG};
        foreach (addrs[i]) begin
            val = next_rand();
            if (addrs[i] == CSR_MTRIG) val = val & 32'h3f;   // six mode bits
            csr_write(addrs[i], val);
            csr_read(1'b0, addrs[i], rd);
            check_data(rd, val, "register read back");
        end
        csr_write(CSR_MTRIG, 32'h0);
        respond(irq_t'(3'b111));   // drop whatever the random modes latched
        csr_read(1'b0, CSR_MISA, rd);
        check_data(rd, 32'h4000_1100, "misa");   // mxl 1, i and m
        csr_read(1'b0, CSR_MARCHID, rd);
        check_data(rd, 32'd1, "marchid");
        csr_read(1'b0, CSR_MIMPID, rd);
        check_data(rd, 32'd1, "mimpid");
        csr_read(1'b0, 12'h7ff, rd);
        check_data(rd, 32'h0, "unknown address");
        val = next_rand();
        write_ports(csr_req_t'{1'b1, CSR_MEPC, val}, csr_req_t'{1'b1, CSR_MEPC, ~val});
        csr_read(1'b0, CSR_MEPC, rd);
        check_data(rd, val, "idex write wins over trap");
        val = next_rand();
        write_ports('0, csr_req_t'{1'b1, CSR_MEPC, val});
        csr_read(1'b1, CSR_MEPC, rd);
        check_data(rd, val, "trap write to mepc");
        check_data(mepc, val, "mepc_o");
        write_ports('0, csr_req_t'{1'b1, CSR_MSTATUS, 32'h88});   // mie and mpie
        check_data({31'h0, mie_global}, 32'h1, "mie_global_o set");
        csr_read(1'b0, CSR_MSTATUS, rd);
        check_data(rd, 32'h1888, "mstatus on idex with mpp 11");
        csr_read(1'b1, CSR_MSTATUS, rd);
        check_data(rd, 32'h88, "mstatus on trap port");
        csr_write(CSR_MSTATUS, 32'h0);
        check_data({31'h0, mie_global}, 32'h0, "mie_global_o clear");
    endtask

    task automatic count_cycles_and_retires();
        logic [31:0] v0, v1, val;
        int          n;
        csr_write(CSR_MCCTR, 32'h1);   // cycle only
        n = 3 + int'(next_rand() % 10);
        csr_read(1'b0, CSR_MCYCLE, v0);
        repeat (n - 1) @(negedge clk);
        csr_read(1'b0, CSR_MCYCLE, v1);
        check_data(v1 - v0, n, "mcycle delta");
        val = next_rand();
        csr_write(CSR_MCYCLE, val);
        csr_read(1'b0, CSR_MCYCLE, v1);
        check_data(v1, val + 32'd1, "mcycle write then one increment");
        csr_write(CSR_MCCTR, 32'h2);   // instret only
        n = 2 + int'(next_rand() % 8);
        csr_read(1'b0, CSR_MINSTRET, v0);
        pulse_retire(n);
        csr_read(1'b0, CSR_MINSTRET, v1);
        check_data(v1 - v0, n, "minstret counts retires");
        csr_write(CSR_MCCTR, 32'h0);
        csr_read(1'b0, CSR_MINSTRET, v0);
        pulse_retire(n);
        csr_read(1'b0, CSR_MINSTRET, v1);
        check_data(v1, v0, "minstret held while disabled");
    endtask

    task automatic fire_timer_irq();
        csr_write(CSR_MTRIG, 32'h0);   // high level on every source
        csr_write(CSR_MIE, 32'h80);   // mtie
        csr_write(CSR_MTIMECMP, 32'd100);
        csr_write(CSR_MTIMECMPH, 32'd0);
        csr_write(CSR_MTIME, 32'd200);   // mtime now past compare
        wait_mip(32'h80, 32'h80, "timer pending");
        check_irq(irq, irq_t'(3'b000), "timer irq before retire");
        pulse_retire(1);
        check_irq(irq, irq_t'(3'b010), "timer irq after retire");
        csr_write(CSR_MTIMECMPH, 32'hffff_ffff);
        respond(irq_t'(3'b010));
        wait_mip(32'h80, 32'h0, "timer pending clear");
        pulse_retire(1);
        check_irq(irq, irq_t'(3'b000), "timer irq cleared on retire");
    endtask

    task automatic trigger_ext_modes();
        logic [31:0] rd;
        csr_write(CSR_MTRIG, 32'(TRIG_RISE));
        @(negedge clk);
        ext_irq = 1'b1;
        wait_mip(32'h800, 32'h800, "ext rising edge pending");
        respond(irq_t'(3'b100));
        repeat (4) @(negedge clk);   // level still high
        csr_read(1'b0, CSR_MIP, rd);
        check_data(rd & 32'h800, 32'h0, "no new pending while held high");
        csr_write(CSR_MTRIG, 32'(TRIG_LOW));
        @(negedge clk);
        ext_irq = 1'b0;
        wait_mip(32'h800, 32'h800, "ext low level pending");
        @(negedge clk);
        ext_irq = 1'b1;
        respond(irq_t'(3'b100));
        wait_mip(32'h800, 32'h0, "ext pending clear");
    endtask

    task automatic mask_sw_and_soft_reset();
        csr_write(CSR_MIE, 32'h0);
        csr_write(CSR_MSIP, next_rand() | 32'h1);
        wait_mip(32'h8, 32'h8, "software pending");
        pulse_retire(1);
        check_irq(irq, irq_t'(3'b000), "masked software irq");
        csr_write(CSR_MIE, 32'h8);   // msie
        pulse_retire(1);
        check_irq(irq, irq_t'(3'b001), "software irq after unmask");
        csr_write(CSR_MCCTR, 32'h8);
        check_data({31'h0, soft_rst}, 32'h1, "soft reset high");
        csr_write(CSR_MCCTR, 32'h0);
        check_data({31'h0, soft_rst}, 32'h0, "soft reset low");
    endtask

    initial begin
        lcg_state   = 32'd3967;
        assert_errs = 0;
        rst_n       = 1'b0;
        idex_req    = '0;
        trap_req    = '0;
        ext_irq     = 1'b0;
        irq_rsp     = '0;
        retire      = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        exercise_registers();
        count_cycles_and_retires();
        fire_timer_irq();
        trigger_ext_modes();
        mask_sw_and_soft_reset();
        repeat (2) @(negedge clk);
        if (assert_errs == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("%0d assertion failures", assert_errs);
            stop_on_error();
        end
    end

endmodule
